// ==== verilog/cp0_defines.svh ====
// ======================================
// CP0 sizes and fixed register values
// ======================================
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// Register width
`define CP0_DATA_W 32

// Hardware interrupt lines, IP[7:2]
`define CP0_HW_INT 6

// Boot vector in kseg1
`define CP0_ERROR_EPC_RST 32'hBFC0_0000

// Company options, company ID, processor ID, revision
`define CP0_PRID 32'h0001_8066

`endif

// ==== verilog/cp0RegPkg.sv ====
// ======================================
// CP0 register numbers, register port and
// Status / Cause field layouts
// ======================================
`include "cp0_defines.svh"

package cp0RegPkg;

    // Only the registers this CP0 implements
    typedef enum logic [4:0] {
        RegBadVAddr = 5'd8,
        RegCount    = 5'd9,
        RegCompare  = 5'd11,
        RegStatus   = 5'd12,
        RegCause    = 5'd13,
        RegEpc      = 5'd14,
        RegPrId     = 5'd15,
        RegErrorEpc = 5'd30
    } regNum_t;

    // MTC0 / MFC0 access from the core
    typedef struct packed {
        regNum_t                 addr;
        logic                    wen;
        logic [`CP0_DATA_W-1:0]  wdata;
    } regReq_t;

    // Implemented Status bits, others read as zero
    typedef struct packed {
        logic       cu0;
        logic       bev;
        logic [7:0] im;
        logic       um;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;
        logic [1:0] ce;       // Unusable coprocessor number
        logic       iv;
        logic [7:0] ip;       // [7:2] hardware, [1:0] software
        logic [4:0] excCode;
    } cause_t;

endpackage

// ==== verilog/cp0ExcPkg.sv ====
// ======================================
// Exception types, ExcCode values and the
// exception request from the pipeline
// ======================================
`include "cp0_defines.svh"

package cp0ExcPkg;

    // Pipeline side classification, ERET included
    typedef enum logic [3:0] {
        ExcIntr = 4'd0,
        ExcCpU  = 4'd1,
        ExcRI   = 4'd2,
        ExcOv   = 4'd3,
        ExcTrap = 4'd4,
        ExcSysC = 4'd5,
        ExcBp   = 4'd6,
        ExcAdE  = 4'd7,
        ExcTLBR = 4'd8,
        ExcTLBI = 4'd9,
        ExcTLBM = 4'd10,
        ExcERET = 4'd11
    } excType_t;

    // Architectural Cause.ExcCode
    typedef enum logic [4:0] {
        CodeInt  = 5'd0,
        CodeMod  = 5'd1,
        CodeTLBL = 5'd2,
        CodeTLBS = 5'd3,
        CodeAdEL = 5'd4,
        CodeAdES = 5'd5,
        CodeSys  = 5'd8,
        CodeBp   = 5'd9,
        CodeRI   = 5'd10,
        CodeCpU  = 5'd11,
        CodeOv   = 5'd12,
        CodeTr   = 5'd13
    } excCode_t;

    typedef struct packed {
        logic                    valid;
        excType_t                excType;
        logic [`CP0_DATA_W-1:0]  pc;
        logic [`CP0_DATA_W-1:0]  badAddr;
        logic [1:0]              cpNum;
        logic                    isStore;   // Selects the store variant of AdE/TLB codes
        logic                    inSlot;    // Faulting instruction in a delay slot
    } excReq_t;

endpackage

// ==== verilog/cp0Timer.sv ====
// ======================================
// CP0 Count/Compare timer with sticky
// timer interrupt
// ======================================
`timescale 1ns/1ps
`include "cp0_defines.svh"

module cp0Timer (
    input  logic                    clk,
    input  logic                    rst,
    input  cp0RegPkg::regReq_t      regReq_i,
    output logic [`CP0_DATA_W-1:0]  countValue_o,
    output logic [`CP0_DATA_W-1:0]  compareValue_o,
    output logic                    timerInt_o
);
    import cp0RegPkg::*;

    // Extra low bit makes Count run at half the clock rate
    logic [`CP0_DATA_W:0]   countHalf;
    logic [`CP0_DATA_W-1:0] compare;
    logic                   timerInt;
    logic                   countWr;
    logic                   compareWr;
    logic                   match;

    assign countWr   = regReq_i.wen && (regReq_i.addr == RegCount);
    assign compareWr = regReq_i.wen && (regReq_i.addr == RegCompare);
    assign match     = (compare != '0) && (countHalf[`CP0_DATA_W:1] == compare);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countHalf <= '0;
            compare   <= '0;
            timerInt  <= 1'b0;
        end else begin
            if (countWr)
                countHalf <= {regReq_i.wdata, 1'b0};
            else
                countHalf <= countHalf + 1'b1;

            if (compareWr) begin
                compare  <= regReq_i.wdata;
                timerInt <= 1'b0;    // Write acknowledges the interrupt
            end else if (match) begin
                timerInt <= 1'b1;
            end
        end
    end

    assign countValue_o   = countHalf[`CP0_DATA_W:1];
    assign compareValue_o = compare;
    assign timerInt_o     = timerInt;

    // A cleared Compare disables the timer
    timerNeedsCompare: assert property (@(posedge clk) disable iff (rst)
        $rose(timerInt_o) |-> $past(compareValue_o != '0));

endmodule

// ==== verilog/cp0ExcUnit.sv ====
// ======================================
// CP0 Status, Cause, EPC, BadVAddr, ErrorEPC
// with exception entry, ERET and interrupts
// ======================================
`timescale 1ns/1ps
`include "cp0_defines.svh"

module cp0ExcUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  cp0RegPkg::regReq_t      regReq_i,
    input  cp0ExcPkg::excReq_t      excReq_i,
    input  logic [`CP0_HW_INT-1:0]  hwInt_i,
    input  logic                    timerInt_i,
    output cp0RegPkg::status_t      status_o,
    output cp0RegPkg::cause_t       cause_o,
    output logic [`CP0_DATA_W-1:0]  epc_o,
    output logic [`CP0_DATA_W-1:0]  badVAddr_o,
    output logic [`CP0_DATA_W-1:0]  errorEpc_o,
    output logic                    userMode_o,
    output logic                    intPending_o
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    status_t                status;
    cause_t                 cause;
    logic [`CP0_DATA_W-1:0] epc;
    logic [`CP0_DATA_W-1:0] badVAddr;
    logic [`CP0_DATA_W-1:0] errorEpc;
    logic [4:0]             nextCode;
    logic                   isEret;
    logic                   kernelLevel;

    assign isEret = (excReq_i.excType == ExcERET);

    // Type to ExcCode, ERET keeps the old code
    always_comb begin
        case (excReq_i.excType)
            ExcIntr: nextCode = CodeInt;
            ExcCpU:  nextCode = CodeCpU;
            ExcRI:   nextCode = CodeRI;
            ExcOv:   nextCode = CodeOv;
            ExcTrap: nextCode = CodeTr;
            ExcSysC: nextCode = CodeSys;
            ExcBp:   nextCode = CodeBp;
            ExcAdE:  nextCode = excReq_i.isStore ? CodeAdES : CodeAdEL;
            ExcTLBR,
            ExcTLBI: nextCode = excReq_i.isStore ? CodeTLBS : CodeTLBL;
            ExcTLBM: nextCode = CodeMod;
            default: nextCode = cause.excCode;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status   <= '{cu0: 1'b0, bev: 1'b1, im: 8'h00, um: 1'b0,
                          erl: 1'b1, exl: 1'b0, ie: 1'b0};
            cause    <= '0;
            epc      <= '0;
            badVAddr <= '0;
            errorEpc <= `CP0_ERROR_EPC_RST;
        end else begin
            // Line 5 shared with the timer
            cause.ip[7:2] <= {hwInt_i[`CP0_HW_INT-1] | timerInt_i,
                              hwInt_i[`CP0_HW_INT-2:0]};

            if (excReq_i.valid) begin
                if (isEret) begin
                    status.exl <= 1'b0;
                end else begin
                    // Nested exceptions keep the first return address
                    if (!status.exl) begin
                        epc      <= excReq_i.inSlot ? excReq_i.pc - 32'd4 : excReq_i.pc;
                        cause.bd <= excReq_i.inSlot;
                    end
                    status.exl    <= 1'b1;
                    cause.excCode <= nextCode;
                end

                case (excReq_i.excType)
                    ExcAdE,
                    ExcTLBR,
                    ExcTLBI,
                    ExcTLBM: badVAddr <= excReq_i.badAddr;
                    ExcCpU:  cause.ce <= excReq_i.cpNum;
                    default: ;
                endcase
            end else if (regReq_i.wen) begin
                case (regReq_i.addr)
                    RegStatus: begin
                        status.cu0 <= regReq_i.wdata[28];
                        status.bev <= regReq_i.wdata[22];
                        status.im  <= regReq_i.wdata[15:8];
                        status.um  <= regReq_i.wdata[4];
                        status.erl <= regReq_i.wdata[2];
                        status.exl <= regReq_i.wdata[1];
                        status.ie  <= regReq_i.wdata[0];
                    end
                    RegCause: begin
                        cause.iv      <= regReq_i.wdata[23];
                        cause.ip[1:0] <= regReq_i.wdata[9:8];   // Software interrupts only
                    end
                    RegEpc:      epc      <= regReq_i.wdata;
                    RegBadVAddr: badVAddr <= regReq_i.wdata;
                    RegErrorEpc: errorEpc <= regReq_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    assign kernelLevel  = status.erl | status.exl;
    assign intPending_o = (|(cause.ip & status.im)) && status.ie && !kernelLevel;
    assign userMode_o   = status.um && !kernelLevel;

    assign status_o   = status;
    assign cause_o    = cause;
    assign epc_o      = epc;
    assign badVAddr_o = badVAddr;
    assign errorEpc_o = errorEpc;

    // Software cannot write ExcCode
    excCodeFromExc: assert property (@(posedge clk) disable iff (rst)
        $changed(cause.excCode) |-> $past(excReq_i.valid));

endmodule

// ==== verilog/cp0ReadMux.sv ====
// ======================================
// CP0 read select and field packing
// ======================================
`timescale 1ns/1ps
`include "cp0_defines.svh"

module cp0ReadMux (
    input  cp0RegPkg::regReq_t      regReq_i,
    input  cp0RegPkg::status_t      status_i,
    input  cp0RegPkg::cause_t       cause_i,
    input  logic [`CP0_DATA_W-1:0]  epc_i,
    input  logic [`CP0_DATA_W-1:0]  badVAddr_i,
    input  logic [`CP0_DATA_W-1:0]  errorEpc_i,
    input  logic [`CP0_DATA_W-1:0]  count_i,
    input  logic [`CP0_DATA_W-1:0]  compare_i,
    output logic [`CP0_DATA_W-1:0]  rdata_o
);
    import cp0RegPkg::*;

    // Architectural word views, also used by the top outputs
    logic [`CP0_DATA_W-1:0] statusWord;
    logic [`CP0_DATA_W-1:0] causeWord;

    assign statusWord = {3'b0, status_i.cu0, 5'b0, status_i.bev, 6'b0,
                         status_i.im, 3'b0, status_i.um, 1'b0,
                         status_i.erl, status_i.exl, status_i.ie};

    assign causeWord = {cause_i.bd, 1'b0, cause_i.ce, 4'b0, cause_i.iv, 7'b0,
                        cause_i.ip, 1'b0, cause_i.excCode, 2'b0};

    always_comb begin
        case (regReq_i.addr)
            RegBadVAddr: rdata_o = badVAddr_i;
            RegCount:    rdata_o = count_i;
            RegCompare:  rdata_o = compare_i;
            RegStatus:   rdata_o = statusWord;
            RegCause:    rdata_o = causeWord;
            RegEpc:      rdata_o = epc_i;
            RegPrId:     rdata_o = `CP0_PRID;
            RegErrorEpc: rdata_o = errorEpc_i;
            default:     rdata_o = '0;   // Unimplemented registers
        endcase
    end

endmodule

// ==== verilog/cp0Top.sv ====
// ======================================
// CP0 top: timer, exception unit, read mux
// ======================================
`timescale 1ns/1ps
`include "cp0_defines.svh"

module cp0Top (
    input  logic                    clk,
    input  logic                    rst,
    input  cp0RegPkg::regReq_t      regReq_i,
    input  cp0ExcPkg::excReq_t      excReq_i,
    input  logic [`CP0_HW_INT-1:0]  hwInt_i,
    output logic [`CP0_DATA_W-1:0]  rdata_o,
    output logic [`CP0_DATA_W-1:0]  status_o,
    output logic [`CP0_DATA_W-1:0]  cause_o,
    output logic [`CP0_DATA_W-1:0]  epc_o,
    output logic [`CP0_DATA_W-1:0]  errorEpc_o,
    output logic                    userMode_o,
    output logic                    intPending_o
);
    import cp0RegPkg::*;

    status_t                statusWord;
    cause_t                 causeFields;
    logic [`CP0_DATA_W-1:0] badVAddr;
    logic [`CP0_DATA_W-1:0] countValue;
    logic [`CP0_DATA_W-1:0] compareValue;
    logic                   timerInt;

    cp0Timer uTimer (
        .clk            (clk),
        .rst            (rst),
        .regReq_i       (regReq_i),
        .countValue_o   (countValue),
        .compareValue_o (compareValue),
        .timerInt_o     (timerInt)
    );

    cp0ExcUnit uExcUnit (
        .clk          (clk),
        .rst          (rst),
        .regReq_i     (regReq_i),
        .excReq_i     (excReq_i),
        .hwInt_i      (hwInt_i),
        .timerInt_i   (timerInt),
        .status_o     (statusWord),
        .cause_o      (causeFields),
        .epc_o        (epc_o),
        .badVAddr_o   (badVAddr),
        .errorEpc_o   (errorEpc_o),
        .userMode_o   (userMode_o),
        .intPending_o (intPending_o)
    );

    cp0ReadMux uReadMux (
        .regReq_i   (regReq_i),
        .status_i   (statusWord),
        .cause_i    (causeFields),
        .epc_i      (epc_o),
        .badVAddr_i (badVAddr),
        .errorEpc_i (errorEpc_o),
        .count_i    (countValue),
        .compare_i  (compareValue),
        .rdata_o    (rdata_o)
    );

    // Packed words come from the mux
    assign status_o = uReadMux.statusWord;
    assign cause_o  = uReadMux.causeWord;

endmodule

// ==== verif/tbClockGen.sv ====
// ======================================
// Testbench clock and reset source
// ======================================
`timescale 1ns/1ps

module tbClockGen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== verif/cp0Tb.sv ====
// ======================================
// CP0 directed testbench: registers,
// exceptions, interrupts, timer, user mode
// ======================================
`timescale 1ns/1ps
`include "cp0_defines.svh"

module cp0Tb;
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int TEST_CYCLES   = 150;   // Rough sum over all tests

    logic                    clk;
    logic                    rst;
    regReq_t                 regReq;
    excReq_t                 excReq;
    logic [`CP0_HW_INT-1:0]  hwInt;
    logic [`CP0_DATA_W-1:0]  rdata;
    logic [`CP0_DATA_W-1:0]  statusWord;
    logic [`CP0_DATA_W-1:0]  causeWord;
    logic [`CP0_DATA_W-1:0]  epc;
    logic [`CP0_DATA_W-1:0]  errorEpc;
    logic                    userMode;
    logic                    intPending;
    logic [31:0]             lcgState;

    tbClockGen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) uClk (
        .clk_o (clk),
        .rst_o (rst)
    );

    cp0Top uut (
        .clk          (clk),
        .rst          (rst),
        .regReq_i     (regReq),
        .excReq_i     (excReq),
        .hwInt_i      (hwInt),
        .rdata_o      (rdata),
        .status_o     (statusWord),
        .cause_o      (causeWord),
        .epc_o        (epc),
        .errorEpc_o   (errorEpc),
        .userMode_o   (userMode),
        .intPending_o (intPending)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Read data is combinational, sampled mid cycle
    task automatic readReg(input logic [4:0] num, output logic [31:0] value);
        @(posedge clk);
        regReq <= '{addr: regNum_t'(num), wen: 1'b0, wdata: '0};
        @(negedge clk);
        value = rdata;
    endtask

    task automatic expectReg(input logic [4:0] num, input string name,
                             input logic [31:0] expected);
        logic [31:0] value;
        readReg(num, value);
        checkEq(name, expected, value);
    endtask

    task automatic writeReg(input logic [4:0] num, input logic [31:0] value);
        @(posedge clk);
        regReq <= '{addr: regNum_t'(num), wen: 1'b1, wdata: value};
        @(posedge clk);
        regReq.wen <= 1'b0;
    endtask

    task automatic raiseExc(input excType_t kind, input logic [31:0] pc,
                            input logic [31:0] badAddr, input logic isStore,
                            input logic inSlot);
        excReq_t req;
        req = '{valid: 1'b1, excType: kind, pc: pc, badAddr: badAddr,
                cpNum: 2'd0, isStore: isStore, inSlot: inSlot};
        @(posedge clk);
        excReq <= req;
        @(posedge clk);
        excReq.valid <= 1'b0;
    endtask

    task automatic resetValues();
        expectReg(RegStatus, "Status", 32'h0040_0004);
        expectReg(RegErrorEpc, "ErrorEPC", 32'hBFC0_0000);
        expectReg(RegPrId, "PrId", 32'h0001_8066);
        expectReg(RegCause, "Cause", 32'h0);
        expectReg(RegEpc, "EPC", 32'h0);
        expectReg(5'd5, "unmapped reg 5", 32'h0);
        checkEq("status_o", 32'h0040_0004, statusWord);
        checkEq("cause_o", 32'h0, causeWord);
        checkEq("epc_o", 32'h0, epc);
        checkEq("errorEpc_o", 32'hBFC0_0000, errorEpc);
        checkEq("userMode", 32'd0, userMode);
        checkEq("intPending", 32'd0, intPending);
    endtask

    task automatic writeMasks();
        logic [31:0] word;
        writeReg(RegStatus, '1);
        expectReg(RegStatus, "Status", 32'h1040_FF17);
        checkEq("status_o", 32'h1040_FF17, statusWord);
        writeReg(RegCause, '1);
        expectReg(RegCause, "Cause", 32'h0080_0300);
        checkEq("cause_o", 32'h0080_0300, causeWord);
        word = nextRand();
        writeReg(RegEpc, word);
        expectReg(RegEpc, "EPC", word);
        checkEq("epc_o", word, epc);
        word = nextRand();
        writeReg(RegErrorEpc, word);
        expectReg(RegErrorEpc, "ErrorEPC", word);
        checkEq("errorEpc_o", word, errorEpc);
        word = nextRand();
        writeReg(RegBadVAddr, word);
        expectReg(RegBadVAddr, "BadVAddr", word);
        writeReg(RegPrId, nextRand());
        expectReg(RegPrId, "PrId", 32'h0001_8066);
        writeReg(RegCause, 32'h0);   // drop software interrupts
    endtask

    task automatic exceptionEntry();
        logic [31:0] pc1;
        logic [31:0] pc3;
        logic [31:0] addr;
        logic [31:0] word;
        writeReg(RegStatus, 32'h0);
        pc1  = nextRand() & ~32'h3;
        addr = nextRand();
        raiseExc(ExcAdE, pc1, addr, 1'b1, 1'b0);
        expectReg(RegEpc, "EPC", pc1);
        readReg(RegStatus, word);
        checkEq("Status.EXL", 32'd1, word[1]);
        readReg(RegCause, word);
        checkEq("Cause.ExcCode", 32'd5, word[6:2]);
        checkEq("Cause.BD", 32'd0, word[31]);
        expectReg(RegBadVAddr, "BadVAddr", addr);

        // Nested, EXL still set
        raiseExc(ExcOv, nextRand() & ~32'h3, 32'h0, 1'b0, 1'b1);
        expectReg(RegEpc, "EPC", pc1);
        readReg(RegCause, word);
        checkEq("Cause.ExcCode", 32'd12, word[6:2]);
        checkEq("Cause.BD", 32'd0, word[31]);
        addr = nextRand();
        raiseExc(ExcTLBM, nextRand() & ~32'h3, addr, 1'b1, 1'b0);
        readReg(RegCause, word);
        checkEq("Cause.ExcCode", 32'd1, word[6:2]);
        expectReg(RegBadVAddr, "BadVAddr", addr);

        raiseExc(ExcERET, 32'h0, 32'h0, 1'b0, 1'b0);
        readReg(RegStatus, word);
        checkEq("Status.EXL", 32'd0, word[1]);

        pc3 = nextRand() & ~32'h3;
        raiseExc(ExcSysC, pc3, 32'h0, 1'b0, 1'b1);
        expectReg(RegEpc, "EPC", pc3 - 32'd4);
        readReg(RegCause, word);
        checkEq("Cause.BD", 32'd1, word[31]);
        checkEq("Cause.ExcCode", 32'd8, word[6:2]);
    endtask

    task automatic interruptSignals();
        logic [31:0] word;
        writeReg(RegStatus, 32'h0000_FF01);
        readReg(RegCause, word);
        checkEq("intPending", 32'd0, intPending);
        writeReg(RegCause, 32'h0000_0100);
        readReg(RegCause, word);
        checkEq("Cause.IP", 32'h01, word[15:8]);
        checkEq("intPending", 32'd1, intPending);
        writeReg(RegStatus, 32'h0000_FF03);   // EXL masks it
        readReg(RegStatus, word);
        checkEq("intPending", 32'd0, intPending);
        writeReg(RegCause, 32'h0);
        writeReg(RegStatus, 32'h0000_FF01);

        @(posedge clk);
        hwInt  <= 6'b000001;
        regReq <= '{addr: RegCause, wen: 1'b0, wdata: '0};
        @(negedge clk);
        checkEq("Cause.IP[2] same cycle", 32'd0, rdata[10]);
        readReg(RegCause, word);
        checkEq("Cause.IP[2]", 32'd1, word[10]);
        checkEq("intPending", 32'd1, intPending);
        @(posedge clk);
        hwInt <= '0;
        readReg(RegCause, word);
        checkEq("Cause.IP", 32'h00, word[15:8]);
        checkEq("intPending", 32'd0, intPending);
    endtask

    task automatic timerMatch();
        logic [31:0] count0;
        logic [31:0] word;
        int          waited;
        logic        seen;
        count0 = (nextRand() & 32'h0FFF_FFFF) | 32'h100;
        writeReg(RegCount, count0);
        expectReg(RegCount, "Count", count0);
        writeReg(RegCompare, count0 + 32'd5);
        writeReg(RegStatus, 32'h0000_8001);
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 20) begin
            readReg(RegCause, word);
            seen = word[15];
            waited++;
        end
        checkEq("Cause.IP[7] within 20 cycles", 32'd1, seen);
        checkEq("intPending", 32'd1, intPending);
        writeReg(RegCompare, 32'h0);
        readReg(RegCause, word);
        checkEq("Cause.IP[7]", 32'd0, word[15]);
        checkEq("intPending", 32'd0, intPending);
    endtask

    task automatic userModeExit();
        logic [31:0] word;
        writeReg(RegStatus, 32'h0000_0010);
        @(negedge clk);
        checkEq("userMode", 32'd1, userMode);
        raiseExc(ExcSysC, nextRand() & ~32'h3, 32'h0, 1'b0, 1'b0);
        @(negedge clk);
        checkEq("userMode", 32'd0, userMode);
        readReg(RegStatus, word);
        checkEq("Status.EXL", 32'd1, word[1]);
    endtask

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD_NS);
        $display("Watchdog expired before the tests completed");
        $display("Test FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        lcgState = 32'd8890;
        regReq   = '0;
        excReq   = '0;
        hwInt    = '0;
        @(negedge rst);
        resetValues();
        writeMasks();
        exceptionEntry();
        interruptSignals();
        timerMatch();
        userModeExit();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/cp0RegPkg.sv
verilog/cp0ExcPkg.sv
verilog/cp0Timer.sv
verilog/cp0ExcUnit.sv
verilog/cp0ReadMux.sv
verilog/cp0Top.sv
verif/tbClockGen.sv
verif/cp0Tb.sv
